/* common/sha256_params.svh */
// SHA-256 size constants: word, block and digest widths,
// round count and block counter width

`ifndef SHA256_PARAMS_SVH
`define SHA256_PARAMS_SVH

// Basic word size of the compression function
`define SHA256_WORD_W 32

// One message block and the resulting digest
`define SHA256_BLOCK_W 512
`define SHA256_DIGEST_W 256

// Compression rounds per block
`define SHA256_ROUNDS 64

// Words in one message block, also the schedule window depth
`define SHA256_BLOCK_WORDS 16

// Width of the completed-block counter
`define SHA256_COUNT_W 6

`endif

/* common/sha256_pkg.sv */
// SHA-256 shared types, initial hash value, round constants
// and the FIPS 180-4 logic functions
`default_nettype none
`include "sha256_params.svh"

package sha256_pkg;

  typedef logic [`SHA256_WORD_W-1:0] sha256_word_t;

  // Word 0 sits in the most significant 32 bits
  typedef sha256_word_t [0:`SHA256_BLOCK_W/`SHA256_WORD_W-1] sha256_block_t;

  // Working variables, also used as the digest with a on top
  typedef struct packed {
    sha256_word_t a;
    sha256_word_t b;
    sha256_word_t c;
    sha256_word_t d;
    sha256_word_t e;
    sha256_word_t f;
    sha256_word_t g;
    sha256_word_t h;
  } sha256_state_t;

  typedef logic [$clog2(`SHA256_ROUNDS)-1:0] round_idx_t;
  typedef logic [`SHA256_COUNT_W-1:0] block_count_t;

  localparam sha256_state_t SHA256_IV = '{
    a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
    e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19
  };

  localparam sha256_word_t SHA256_K [`SHA256_ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Rotate right by n bits
  function automatic sha256_word_t rotr(input sha256_word_t x, input int n);
    return (x >> n) | (x << (`SHA256_WORD_W - n));
  endfunction

  function automatic sha256_word_t ch(input sha256_word_t x, y, z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic sha256_word_t maj(input sha256_word_t x, y, z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

  // Round functions on a and e
  function automatic sha256_word_t big_sigma0(input sha256_word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic sha256_word_t big_sigma1(input sha256_word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // Schedule expansion functions
  function automatic sha256_word_t small_sigma0(input sha256_word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic sha256_word_t small_sigma1(input sha256_word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

endpackage

`default_nettype wire

/* design/hash_chain_ctrl.sv */
// Block chaining controller: block acceptance, chaining register,
// block counter and done flag
`timescale 1ns/1ps
`default_nettype none

module hash_chain_ctrl (
  input  wire logic                 clk,
  input  wire logic                 block_load,
  input  wire logic                 block_start,
  input  wire logic                 message_load,
  input  wire logic                 core_done,
  input  wire sha256_pkg::sha256_state_t digest,
  output logic                      core_start,
  output sha256_pkg::sha256_state_t chain_value,
  output logic                      block_ready,
  output logic                      done,
  output sha256_pkg::block_count_t  block_count
);

  import sha256_pkg::*;

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_HASHING,
    CTRL_COMPLETE
  } ctrl_state_t;

  ctrl_state_t state;
  // Set when the block in flight closes the message
  logic        last_block;

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      state       <= CTRL_IDLE;
      core_start  <= 1'b0;
      last_block  <= 1'b0;
      chain_value <= SHA256_IV;
      block_count <= '0;
    end else begin
      core_start <= 1'b0;
      case (state)
        CTRL_IDLE: begin
          if (block_start) begin
            core_start <= 1'b1;
            last_block <= !message_load;
            state      <= CTRL_HASHING;
          end
        end
        CTRL_HASHING: begin
          if (core_done) begin
            chain_value <= digest;
            block_count <= block_count + 1'b1;
            state       <= last_block ? CTRL_COMPLETE : CTRL_IDLE;
          end
        end
        // Holds until the next reset
        CTRL_COMPLETE: state <= CTRL_COMPLETE;
        default:       state <= CTRL_IDLE;
      endcase
    end
  end

  assign block_ready = (state == CTRL_IDLE);
  assign done        = (state == CTRL_COMPLETE);

endmodule

`default_nettype wire

/* design/sha256_hasher.sv */
// SHA-256 hasher top level: block chaining controller
// and compression core
`timescale 1ns/1ps
`default_nettype none

module sha256_hasher (
  input  wire logic                     clk,
  input  wire logic                     block_load,
  input  wire logic                     block_start,
  input  wire logic                     message_load,
  input  wire sha256_pkg::sha256_block_t block,
  output logic                          block_ready,
  output logic                          done,
  output sha256_pkg::sha256_state_t     hash,
  output sha256_pkg::block_count_t      block_count
);

  import sha256_pkg::*;

  logic          core_start;
  logic          core_done;
  sha256_state_t digest;

  // Chaining value doubles as the visible hash
  hash_chain_ctrl u_ctrl (
    .clk          (clk),
    .block_load   (block_load),
    .block_start  (block_start),
    .message_load (message_load),
    .core_done    (core_done),
    .digest       (digest),
    .core_start   (core_start),
    .chain_value  (hash),
    .block_ready  (block_ready),
    .done         (done),
    .block_count  (block_count)
  );

  sha256_core u_core (
    .clk         (clk),
    .block_load  (block_load),
    .core_start  (core_start),
    .block       (block),
    .chain_value (hash),
    .core_done   (core_done),
    .digest      (digest)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the SHA-256 testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module sha256_tb -f tb.f -o sha256_sim
./obj_dir/sha256_sim

/* sha256_core/message_schedule.sv */
// SHA-256 message schedule: 16-word sliding window
// that yields W for the current round
`timescale 1ns/1ps
`default_nettype none
`include "sha256_params.svh"

module message_schedule (
  input  wire logic                     clk,
  input  wire logic                     block_load,
  input  wire logic                     load,
  input  wire logic                     advance,
  input  wire sha256_pkg::sha256_block_t block,
  output sha256_pkg::sha256_word_t      w_t
);

  import sha256_pkg::*;

  localparam int LAST = `SHA256_BLOCK_WORDS - 1;

  // Word 0 is the oldest, W of the current round
  sha256_block_t window;
  sha256_word_t  w_new;

  // W[t+16] from W[t+14], W[t+9], W[t+1] and W[t]
  assign w_new = small_sigma1(window[LAST - 1]) + window[LAST - 6] +
                 small_sigma0(window[1]) + window[0];

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      window <= '0;
    end else if (load) begin
      window <= block;
    end else if (advance) begin
      window <= {window[1:LAST], w_new};
    end
  end

  assign w_t = window[0];

endmodule

`default_nettype wire

/* sha256_core/sha256_core.sv */
// SHA-256 compression core: round FSM, working variables
// and feed-forward addition
`timescale 1ns/1ps
`default_nettype none
`include "sha256_params.svh"

module sha256_core (
  input  wire logic                     clk,
  input  wire logic                     block_load,
  input  wire logic                     core_start,
  input  wire sha256_pkg::sha256_block_t block,
  input  wire sha256_pkg::sha256_state_t chain_value,
  output logic                          core_done,
  output sha256_pkg::sha256_state_t     digest
);

  import sha256_pkg::*;

  localparam int STATE_WORDS = `SHA256_DIGEST_W / `SHA256_WORD_W;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_ROUNDS,
    CORE_FF
  } core_state_t;

  core_state_t   state;
  round_idx_t    round;
  sha256_state_t work;
  sha256_state_t work_next;
  sha256_word_t  w_t;
  sha256_word_t  t1;
  sha256_word_t  t2;
  logic          sched_load;
  logic          sched_advance;

  always_ff @(posedge clk or negedge block_load) begin
    if (!block_load) begin
      state <= CORE_IDLE;
      round <= '0;
    end else begin
      case (state)
        CORE_IDLE: begin
          round <= '0;
          if (core_start) state <= CORE_ROUNDS;
        end
        CORE_ROUNDS: begin
          round <= round + 1'b1;
          if (round == round_idx_t'(`SHA256_ROUNDS - 1)) state <= CORE_FF;
        end
        CORE_FF: state <= CORE_IDLE;
        default: state <= CORE_IDLE;
      endcase
    end
  end

  // Working variables start from the chaining value
  always_ff @(posedge clk) begin
    if (state == CORE_IDLE && core_start) begin
      work <= chain_value;
    end else if (state == CORE_ROUNDS) begin
      work <= work_next;
    end
  end

  // One compression round
  always_comb begin
    t1 = work.h + big_sigma1(work.e) + ch(work.e, work.f, work.g) + SHA256_K[round] + w_t;
    t2 = big_sigma0(work.a) + maj(work.a, work.b, work.c);
    work_next = '{a: t1 + t2, b: work.a, c: work.b, d: work.c,
                  e: work.d + t1, f: work.e, g: work.f, h: work.g};
  end

  // Window follows the input while idle, so it holds the block
  // sampled on the accepting edge once core_start arrives
  assign sched_load    = (state == CORE_IDLE) && !core_start;
  assign sched_advance = (state == CORE_ROUNDS);

  message_schedule u_sched (
    .clk        (clk),
    .block_load (block_load),
    .load       (sched_load),
    .advance    (sched_advance),
    .block      (block),
    .w_t        (w_t)
  );

  // Feed-forward, word by word
  always_comb begin
    for (int i = 0; i < STATE_WORDS; i++) begin
      digest[i*`SHA256_WORD_W +: `SHA256_WORD_W] =
        work[i*`SHA256_WORD_W +: `SHA256_WORD_W] +
        chain_value[i*`SHA256_WORD_W +: `SHA256_WORD_W];
    end
  end

  assign core_done = (state == CORE_FF);

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/sha256_pkg.sv
sha256_core/message_schedule.sv
sha256_core/sha256_core.sv
design/hash_chain_ctrl.sv
design/sha256_hasher.sv
verif/sha256_tb.sv

/* verif/sha256_tb.sv */
// SHA-256 hasher testbench: clock, reset, stimulus, reference
// compression function, compare tasks and checks
`timescale 1ns/1ps
`default_nettype none
`include "sha256_params.svh"

module sha256_tb;

  import sha256_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam sha256_state_t ABC_DIGEST =
    256'hba7816bf_8f01cfea_414140de_5dae2223_b00361a3_96177a9c_b410ff61_f20015ad;

  logic          clk;
  logic          block_load;
  logic          block_start;
  logic          message_load;
  sha256_block_t block;
  logic          block_ready;
  logic          done;
  sha256_state_t hash;
  block_count_t  block_count;

  // Blocks of the next message, and the results the checker expects
  sha256_block_t msg_q[$];
  sha256_state_t exp_digest_q[$];
  block_count_t  exp_count_q[$];
  // Reference digest of the most recent message
  sha256_state_t final_digest;
  string         test_name;
  int            checked = 0;
  logic          done_prev = 1'b0;

  sha256_hasher dut (
    .clk          (clk),
    .block_load   (block_load),
    .block_start  (block_start),
    .message_load (message_load),
    .block        (block),
    .block_ready  (block_ready),
    .done         (done),
    .hash         (hash),
    .block_count  (block_count)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] ror(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // One FIPS 180-4 compression of block m on chaining value hin
  function automatic sha256_state_t ref_compress(input sha256_state_t hin,
                                                 input sha256_block_t m);
    logic [31:0] w [64];
    logic [31:0] v [8];
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] t1;
    logic [31:0] t2;
    sha256_state_t hout;
    for (int t = 0; t < 16; t++) w[t] = m[t];
    for (int t = 16; t < `SHA256_ROUNDS; t++) begin
      s0 = ror(w[t-15], 7) ^ ror(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = ror(w[t-2], 17) ^ ror(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = s1 + w[t-7] + s0 + w[t-16];
    end
    for (int i = 0; i < 8; i++) v[i] = hin[255 - 32*i -: 32];
    for (int t = 0; t < `SHA256_ROUNDS; t++) begin
      s1 = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA256_K[t] + w[t];
      s0 = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      for (int i = 7; i > 0; i--) v[i] = v[i-1];
      // e takes the old d plus t1
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) hout[255 - 32*i -: 32] = hin[255 - 32*i -: 32] + v[i];
    return hout;
  endfunction

  function automatic sha256_block_t random_block();
    sha256_block_t b;
    for (int i = 0; i < `SHA256_BLOCK_WORDS; i++) b[i] = $urandom();
    return b;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_digest(input string what, input sha256_state_t exp,
                              input sha256_state_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s / %s: expected %h, actual %h", test_name, what, exp, act));
  endtask

  task automatic check_count(input string what, input block_count_t exp,
                             input block_count_t act);
    if (act !== exp)
      abort_run($sformatf("Fail %s / %s: expected %0d, actual %0d", test_name, what, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("Fail %s / %s: expected %b, actual %b", test_name, what, exp, act));
  endtask

  // Compares the result of each message when done rises
  always @(negedge clk) begin
    if (done && !done_prev) begin
      if (exp_digest_q.size() == 0) abort_run("done rose with no message outstanding");
      check_digest("message digest", exp_digest_q.pop_front(), hash);
      check_count("message block count", exp_count_q.pop_front(), block_count);
      checked++;
    end
    done_prev = done;
  end

  task automatic wait_idle();
    int n;
    n = 0;
    while (!block_ready && !done) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("Timeout waiting for block_ready or done");
    end
  endtask

  task automatic wait_checked(input int target);
    int n;
    n = 0;
    while (checked < target) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT_CYCLES) abort_run("Timeout waiting for the digest check");
    end
  endtask

  task automatic apply_reset();
    block_load = 1'b0;
    repeat (8) @(negedge clk);
    block_load = 1'b1;
  endtask

  task automatic check_reset_values();
    check_flag("block_ready after reset", 1'b1, block_ready);
    check_flag("done after reset", 1'b0, done);
    check_digest("hash after reset", SHA256_IV, hash);
    check_count("block_count after reset", '0, block_count);
  endtask

  // Optional stray start while the accepted block is hashed
  task automatic send_block(input sha256_block_t blk, input logic more, input logic stray);
    wait_idle();
    check_flag("block_ready before start", 1'b1, block_ready);
    block        = blk;
    message_load = more;
    block_start  = 1'b1;
    @(negedge clk);
    block_start = 1'b0;
    if (stray) begin
      check_flag("block_ready while hashing", 1'b0, block_ready);
      block        = random_block();
      message_load = 1'b0;
      block_start  = 1'b1;
      @(negedge clk);
      block_start = 1'b0;
    end
    wait_idle();
  endtask

  task automatic run_message(input logic stray);
    sha256_state_t h;
    int target;
    target = checked + 1;
    h = SHA256_IV;
    foreach (msg_q[i]) h = ref_compress(h, msg_q[i]);
    final_digest = h;
    exp_digest_q.push_back(h);
    exp_count_q.push_back(block_count_t'(msg_q.size()));
    foreach (msg_q[i]) send_block(msg_q[i], i != msg_q.size() - 1, stray && i == 0);
    wait_checked(target);
    check_flag("done at end of message", 1'b1, done);
    check_flag("block_ready after done", 1'b0, block_ready);
  endtask

  initial begin
    sha256_block_t abc_block;
    sha256_state_t saved;
    clk          = 1'b0;
    block_load   = 1'b0;
    block_start  = 1'b0;
    message_load = 1'b0;
    block        = '0;
    test_name    = "reset";
    void'($urandom(32'h560c_f044));
    apply_reset();
    check_reset_values();

    // Padded single block "abc"
    test_name = "abc block";
    abc_block = '0;
    abc_block[0] = 32'h61626380;
    abc_block[15] = 32'h00000018;
    check_digest("reference model", ABC_DIGEST, ref_compress(SHA256_IV, abc_block));
    msg_q = {abc_block};
    run_message(1'b0);
    check_count("abc block count", 6'd1, block_count);

    test_name = "three chained blocks";
    apply_reset();
    msg_q = {random_block(), random_block(), random_block()};
    run_message(1'b0);

    test_name = "start while busy";
    apply_reset();
    msg_q = {random_block(), random_block()};
    run_message(1'b1);

    // Starts after done must leave the result alone
    test_name = "start after done";
    saved = final_digest;
    repeat (2) begin
      block       = random_block();
      block_start = 1'b1;
      @(negedge clk);
      block_start = 1'b0;
      repeat (70) @(negedge clk);
    end
    check_digest("hash after done", saved, hash);
    check_flag("done held", 1'b1, done);
    check_count("block_count held", 6'd2, block_count);

    // First block completes, so hash and count have left their reset values
    test_name = "reset mid hash";
    apply_reset();
    send_block(random_block(), 1'b1, 1'b0);
    block        = random_block();
    message_load = 1'b0;
    block_start  = 1'b1;
    @(negedge clk);
    block_start = 1'b0;
    repeat (20) @(negedge clk);
    apply_reset();
    check_reset_values();
    msg_q = {random_block()};
    run_message(1'b0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
